/* include/jtag_dtm_cfg.svh */
`ifndef JTAG_DTM_CFG_SVH
`define JTAG_DTM_CFG_SVH

// instruction register width
// the debug transport needs at least 5 bits
`define JTAG_IR_WIDTH 5

// instruction codes, IR width each
`define JTAG_INSTR_IDCODE 5'h01
`define JTAG_INSTR_CUSTOM 5'h0a
`define JTAG_INSTR_DMI 5'h11
`define JTAG_INSTR_BYPASS 5'h1f

// device id, read only
`define JTAG_IDCODE_VAL 32'h12345678

// custom test register after reset
`define JTAG_CUSTOM_RST 32'h0A0B0C0D

// flops per pin in the input synchronizer
// must be 2 or more
`define JTAG_SYNC_STAGES 2

`endif

/* hdl/jtag_dtm_pkg.sv */
`default_nettype none

`include "jtag_dtm_cfg.svh"

package jtag_dtm_pkg;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        TAP_TLR      = 4'h0,
        TAP_RTI      = 4'h1,
        TAP_SEL_DR   = 4'h2,
        TAP_CAP_DR   = 4'h3,
        TAP_SHIFT_DR = 4'h4,
        TAP_EXIT1_DR = 4'h5,
        TAP_PAUSE_DR = 4'h6,
        TAP_EXIT2_DR = 4'h7,
        TAP_UPD_DR   = 4'h8,
        TAP_SEL_IR   = 4'h9,
        TAP_CAP_IR   = 4'ha,
        TAP_SHIFT_IR = 4'hb,
        TAP_EXIT1_IR = 4'hc,
        TAP_PAUSE_IR = 4'hd,
        TAP_EXIT2_IR = 4'he,
        TAP_UPD_IR   = 4'hf
    } tap_state_e;

    typedef logic [`JTAG_IR_WIDTH-1:0] instr_t;

    // op field toward the debug module
    typedef enum logic [1:0] {
        DMI_OP_NOP   = 2'd0,
        DMI_OP_READ  = 2'd1,
        DMI_OP_WRITE = 2'd2,
        DMI_OP_RSVD  = 2'd3
    } dmi_op_e;

    // same field coming back, 0 means the access went through
    localparam dmi_op_e DMI_STATUS_SUCCESS = DMI_OP_NOP;

    typedef logic [9:0] dmi_addr_t;
    typedef logic [31:0] dmi_data_t;

    // 44 bit dmi register, op sits in the low bits
    typedef struct packed {
        dmi_addr_t addr;
        dmi_data_t data;
        dmi_op_e   op;
    } dmi_req_t;

    typedef logic [31:0] word_t;

endpackage

`default_nettype wire

/* hdl/tck_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_dtm_cfg.svh"

module tck_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic jtag_clk_i,
    input  logic jtag_tms_i,
    input  logic jtag_tdi_i,
    output logic tck_rise_o,
    output logic tck_fall_o,
    output logic tms_o,
    output logic tdi_o
);

    localparam int N = `JTAG_SYNC_STAGES;

    // pin chains, newest sample in bit 0
    logic [N-1:0] tck_sync_q;
    logic [N-1:0] tms_sync_q;
    logic [N-1:0] tdi_sync_q;
    // last synchronized tck level
    logic         tck_prev_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tck_sync_q <= '0;
            tms_sync_q <= '1;
            tdi_sync_q <= '0;
            tck_prev_q <= 1'b0;
            tck_rise_o <= 1'b0;
            tck_fall_o <= 1'b0;
            tms_o      <= 1'b1;
            tdi_o      <= 1'b0;
        end
        else
        begin
            tck_sync_q <= {tck_sync_q[N-2:0], jtag_clk_i};
            tms_sync_q <= {tms_sync_q[N-2:0], jtag_tms_i};
            tdi_sync_q <= {tdi_sync_q[N-2:0], jtag_tdi_i};
            tck_prev_q <= tck_sync_q[N-1];
            // edge strobes, one clk each
            tck_rise_o <= tck_sync_q[N-1] & ~tck_prev_q;
            tck_fall_o <= ~tck_sync_q[N-1] & tck_prev_q;
            // data registered alongside so it lines up with the strobes
            tms_o      <= tms_sync_q[N-1];
            tdi_o      <= tdi_sync_q[N-1];
        end
    end

endmodule

`default_nettype wire

/* hdl/tap_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module tap_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tck_rise_i,
    input  logic                    tms_i,
    output logic                    capture_dr_o,
    output logic                    shift_dr_o,
    output logic                    update_dr_o,
    output logic                    capture_ir_o,
    output logic                    shift_ir_o,
    output logic                    update_ir_o,
    output logic                    tlr_o,
    output jtag_dtm_pkg::tap_state_e state_o
);

    jtag_dtm_pkg::tap_state_e state_q;
    jtag_dtm_pkg::tap_state_e state_d;

    // standard 16 state graph, tms picks the branch
    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            jtag_dtm_pkg::TAP_TLR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_TLR : jtag_dtm_pkg::TAP_RTI;
            jtag_dtm_pkg::TAP_RTI:
                state_d = tms_i ? jtag_dtm_pkg::TAP_SEL_DR : jtag_dtm_pkg::TAP_RTI;
            jtag_dtm_pkg::TAP_SEL_DR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_SEL_IR : jtag_dtm_pkg::TAP_CAP_DR;
            jtag_dtm_pkg::TAP_CAP_DR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_EXIT1_DR : jtag_dtm_pkg::TAP_SHIFT_DR;
            jtag_dtm_pkg::TAP_SHIFT_DR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_EXIT1_DR : jtag_dtm_pkg::TAP_SHIFT_DR;
            jtag_dtm_pkg::TAP_EXIT1_DR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_UPD_DR : jtag_dtm_pkg::TAP_PAUSE_DR;
            // pause holds while tms is low
            jtag_dtm_pkg::TAP_PAUSE_DR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_EXIT2_DR : jtag_dtm_pkg::TAP_PAUSE_DR;
            jtag_dtm_pkg::TAP_EXIT2_DR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_UPD_DR : jtag_dtm_pkg::TAP_SHIFT_DR;
            jtag_dtm_pkg::TAP_UPD_DR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_SEL_DR : jtag_dtm_pkg::TAP_RTI;
            // ir column, a second tms one here falls back to reset
            jtag_dtm_pkg::TAP_SEL_IR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_TLR : jtag_dtm_pkg::TAP_CAP_IR;
            jtag_dtm_pkg::TAP_CAP_IR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_EXIT1_IR : jtag_dtm_pkg::TAP_SHIFT_IR;
            jtag_dtm_pkg::TAP_SHIFT_IR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_EXIT1_IR : jtag_dtm_pkg::TAP_SHIFT_IR;
            jtag_dtm_pkg::TAP_EXIT1_IR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_UPD_IR : jtag_dtm_pkg::TAP_PAUSE_IR;
            jtag_dtm_pkg::TAP_PAUSE_IR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_EXIT2_IR : jtag_dtm_pkg::TAP_PAUSE_IR;
            jtag_dtm_pkg::TAP_EXIT2_IR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_UPD_IR : jtag_dtm_pkg::TAP_SHIFT_IR;
            jtag_dtm_pkg::TAP_UPD_IR:
                state_d = tms_i ? jtag_dtm_pkg::TAP_SEL_DR : jtag_dtm_pkg::TAP_RTI;
            default:
                state_d = jtag_dtm_pkg::TAP_TLR;
        endcase
    end

    // state moves only on a synchronized tck rise
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= jtag_dtm_pkg::TAP_TLR;
        end
        else if (tck_rise_i)
        begin
            state_q <= state_d;
        end
    end

    // strobes fire on the rise that leaves the state
    // shift fires regardless of tms so the last bit goes out on exit
    assign capture_dr_o = tck_rise_i && (state_q == jtag_dtm_pkg::TAP_CAP_DR);
    assign shift_dr_o   = tck_rise_i && (state_q == jtag_dtm_pkg::TAP_SHIFT_DR);
    assign update_dr_o  = tck_rise_i && tms_i &&
                          ((state_q == jtag_dtm_pkg::TAP_EXIT1_DR) ||
                           (state_q == jtag_dtm_pkg::TAP_EXIT2_DR));
    assign capture_ir_o = tck_rise_i && (state_q == jtag_dtm_pkg::TAP_CAP_IR);
    assign shift_ir_o   = tck_rise_i && (state_q == jtag_dtm_pkg::TAP_SHIFT_IR);
    assign update_ir_o  = tck_rise_i && tms_i &&
                          ((state_q == jtag_dtm_pkg::TAP_EXIT1_IR) ||
                           (state_q == jtag_dtm_pkg::TAP_EXIT2_IR));

    assign tlr_o   = (state_q == jtag_dtm_pkg::TAP_TLR);
    assign state_o = state_q;

endmodule

`default_nettype wire

/* hdl/scan_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_reg #(
    parameter type      payload_t = logic [31:0],
    // value of the update stage after reset
    parameter payload_t RESET_VAL = payload_t'('0)
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     capture_i,
    input  logic     shift_i,
    input  logic     update_i,
    input  logic     tdi_i,
    input  payload_t capture_val_i,
    output logic     tdo_o,
    output payload_t update_val_o
);

    localparam int W = $bits(payload_t);

    // shift stage, bit 0 goes out first
    logic [W-1:0] shift_q;
    // update stage seen by the logic behind the register
    payload_t     update_q;

    // capture and shift are exclusive, both come from the tap fsm
    always_ff @(posedge clk)
    begin
        if (capture_i)
        begin
            shift_q <= capture_val_i;
        end
        else if (shift_i)
        begin
            // tdi in at the top, everything moves toward the lsb
            shift_q <= {tdi_i, shift_q[W-1:1]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            update_q <= RESET_VAL;
        end
        else if (update_i)
        begin
            update_q <= payload_t'(shift_q);
        end
    end

    assign tdo_o        = shift_q[0];
    assign update_val_o = update_q;

endmodule

`default_nettype wire

/* hdl/instr_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_dtm_cfg.svh"

module instr_reg (
    input  logic clk,
    input  logic rst_n,
    input  logic tck_rise_i,
    input  logic capture_i,
    input  logic shift_i,
    input  logic update_i,
    input  logic tlr_i,
    input  logic tdi_i,
    output logic tdo_o,
    output logic sel_idcode_o,
    output logic sel_dmi_o,
    output logic sel_custom_o,
    output logic sel_bypass_o
);

    // captured into the shift stage, 1149.1 wants 01 in the low bits
    localparam jtag_dtm_pkg::instr_t IR_CAPTURE = jtag_dtm_pkg::instr_t'(1);

    jtag_dtm_pkg::instr_t ir_shift_q;
    jtag_dtm_pkg::instr_t ir_q;

    always_ff @(posedge clk)
    begin
        if (capture_i)
        begin
            ir_shift_q <= IR_CAPTURE;
        end
        else if (shift_i)
        begin
            ir_shift_q <= {tdi_i, ir_shift_q[`JTAG_IR_WIDTH-1:1]};
        end
    end

    // test-logic-reset acts on tck edges like the rest of the tap
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ir_q <= `JTAG_INSTR_IDCODE;
        end
        else if (tlr_i && tck_rise_i)
        begin
            ir_q <= `JTAG_INSTR_IDCODE;
        end
        else if (update_i)
        begin
            ir_q <= ir_shift_q;
        end
    end

    // exactly one select, anything unknown lands on bypass
    always_comb
    begin
        sel_idcode_o = 1'b0;
        sel_dmi_o    = 1'b0;
        sel_custom_o = 1'b0;
        sel_bypass_o = 1'b0;
        case (ir_q)
            `JTAG_INSTR_IDCODE: sel_idcode_o = 1'b1;
            `JTAG_INSTR_DMI:    sel_dmi_o    = 1'b1;
            `JTAG_INSTR_CUSTOM: sel_custom_o = 1'b1;
            `JTAG_INSTR_BYPASS: sel_bypass_o = 1'b1;
            default:            sel_bypass_o = 1'b1;
        endcase
    end

    assign tdo_o = ir_shift_q[0];

endmodule

`default_nettype wire

/* hdl/dmi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module dmi_bridge (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   update_i,
    input  logic                   ack_i,
    input  jtag_dtm_pkg::dmi_req_t  update_val_i,
    input  jtag_dtm_pkg::dmi_data_t rdata_i,
    output jtag_dtm_pkg::dmi_req_t  capture_val_o,
    output logic                   start_read_o,
    output logic                   start_write_o,
    output jtag_dtm_pkg::dmi_addr_t addr_o,
    output jtag_dtm_pkg::dmi_data_t wdata_o
);

    // dmi data register, returned on the next capture
    jtag_dtm_pkg::dmi_req_t  req_q;
    // bus side copies, stable until the next update
    jtag_dtm_pkg::dmi_addr_t addr_q;
    jtag_dtm_pkg::dmi_data_t wdata_q;
    logic                    start_read_q;
    logic                    start_write_q;

    // no back-pressure, an update always wins over an ack
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            req_q         <= '0;
            start_read_q  <= 1'b0;
            start_write_q <= 1'b0;
        end
        else
        begin
            // strobes last one clk
            start_read_q  <= 1'b0;
            start_write_q <= 1'b0;
            if (update_i)
            begin
                req_q         <= update_val_i;
                start_read_q  <= (update_val_i.op == jtag_dtm_pkg::DMI_OP_READ);
                start_write_q <= (update_val_i.op == jtag_dtm_pkg::DMI_OP_WRITE);
            end
            else if (ack_i)
            begin
                // read data replaces the data field, address stays
                req_q.data <= rdata_i;
                req_q.op   <= jtag_dtm_pkg::DMI_STATUS_SUCCESS;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (update_i)
        begin
            addr_q  <= update_val_i.addr;
            wdata_q <= update_val_i.data;
        end
    end

    assign capture_val_o = req_q;
    assign start_read_o  = start_read_q;
    assign start_write_o = start_write_q;
    assign addr_o        = addr_q;
    assign wdata_o       = wdata_q;

endmodule

`default_nettype wire

/* hdl/jtag_dtm_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_dtm_cfg.svh"

module jtag_dtm_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   jtag_clk_i,
    input  logic                   jtag_tms_i,
    input  logic                   jtag_tdi_i,
    output logic                   jtag_tdo_o,
    input  jtag_dtm_pkg::dmi_data_t rdata_i,
    input  logic                   ack_i,
    output logic                   start_read_o,
    output logic                   start_write_o,
    output jtag_dtm_pkg::dmi_addr_t addr_o,
    output jtag_dtm_pkg::dmi_data_t wdata_o
);

    logic tck_rise;
    logic tck_fall;
    logic tms;
    logic tdi;

    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic tlr;
    jtag_dtm_pkg::tap_state_e tap_state;

    logic sel_idcode;
    logic sel_dmi;
    logic sel_custom;
    logic sel_bypass;

    logic ir_tdo;
    logic idcode_tdo;
    logic custom_tdo;
    logic dmi_tdo;
    logic dr_tdo;

    jtag_dtm_pkg::word_t    custom_val;
    jtag_dtm_pkg::dmi_req_t dmi_capture;
    jtag_dtm_pkg::dmi_req_t dmi_update;
    // dmi update strobe, one clk behind the scan register
    logic                   dmi_update_q;

    logic bypass_q;
    logic tdo_q;

    tck_sync tck_sync_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .jtag_clk_i (jtag_clk_i),
        .jtag_tms_i (jtag_tms_i),
        .jtag_tdi_i (jtag_tdi_i),
        .tck_rise_o (tck_rise),
        .tck_fall_o (tck_fall),
        .tms_o      (tms),
        .tdi_o      (tdi)
    );

    tap_fsm tap_fsm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tck_rise_i   (tck_rise),
        .tms_i        (tms),
        .capture_dr_o (capture_dr),
        .shift_dr_o   (shift_dr),
        .update_dr_o  (update_dr),
        .capture_ir_o (capture_ir),
        .shift_ir_o   (shift_ir),
        .update_ir_o  (update_ir),
        .tlr_o        (tlr),
        .state_o      (tap_state)
    );

    instr_reg instr_reg_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tck_rise_i   (tck_rise),
        .capture_i    (capture_ir),
        .shift_i      (shift_ir),
        .update_i     (update_ir),
        .tlr_i        (tlr),
        .tdi_i        (tdi),
        .tdo_o        (ir_tdo),
        .sel_idcode_o (sel_idcode),
        .sel_dmi_o    (sel_dmi),
        .sel_custom_o (sel_custom),
        .sel_bypass_o (sel_bypass)
    );

    // device id, update path tied off
    scan_reg #(
        .payload_t (jtag_dtm_pkg::word_t)
    ) idcode_reg_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_i     (capture_dr && sel_idcode),
        .shift_i       (shift_dr && sel_idcode),
        .update_i      (1'b0),
        .tdi_i         (tdi),
        .capture_val_i (`JTAG_IDCODE_VAL),
        .tdo_o         (idcode_tdo),
        .update_val_o  ()
    );

    // read/write test register, captures its own last update
    scan_reg #(
        .payload_t (jtag_dtm_pkg::word_t),
        .RESET_VAL (`JTAG_CUSTOM_RST)
    ) custom_reg_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_i     (capture_dr && sel_custom),
        .shift_i       (shift_dr && sel_custom),
        .update_i      (update_dr && sel_custom),
        .tdi_i         (tdi),
        .capture_val_i (custom_val),
        .tdo_o         (custom_tdo),
        .update_val_o  (custom_val)
    );

    scan_reg #(
        .payload_t (jtag_dtm_pkg::dmi_req_t)
    ) dmi_reg_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_i     (capture_dr && sel_dmi),
        .shift_i       (shift_dr && sel_dmi),
        .update_i      (update_dr && sel_dmi),
        .tdi_i         (tdi),
        .capture_val_i (dmi_capture),
        .tdo_o         (dmi_tdo),
        .update_val_o  (dmi_update)
    );

    // the update stage loads on the strobe edge
    // so the bridge takes the new request one clk later
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dmi_update_q <= 1'b0;
        end
        else
        begin
            dmi_update_q <= update_dr && sel_dmi;
        end
    end

    dmi_bridge dmi_bridge_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .update_i      (dmi_update_q),
        .ack_i         (ack_i),
        .update_val_i  (dmi_update),
        .rdata_i       (rdata_i),
        .capture_val_o (dmi_capture),
        .start_read_o  (start_read_o),
        .start_write_o (start_write_o),
        .addr_o        (addr_o),
        .wdata_o       (wdata_o)
    );

    // bypass is one flop, captures 0
    always_ff @(posedge clk)
    begin
        if (capture_dr && sel_bypass)
        begin
            bypass_q <= 1'b0;
        end
        else if (shift_dr && sel_bypass)
        begin
            bypass_q <= tdi;
        end
    end

    always_comb
    begin
        if (sel_idcode)
            dr_tdo = idcode_tdo;
        else if (sel_dmi)
            dr_tdo = dmi_tdo;
        else if (sel_custom)
            dr_tdo = custom_tdo;
        else
            dr_tdo = bypass_q;
    end

    // tdo changes on falling tck only, holds outside the shift states
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tdo_q <= 1'b0;
        end
        else if (tck_fall && (tap_state == jtag_dtm_pkg::TAP_SHIFT_IR))
        begin
            tdo_q <= ir_tdo;
        end
        else if (tck_fall && (tap_state == jtag_dtm_pkg::TAP_SHIFT_DR))
        begin
            tdo_q <= dr_tdo;
        end
    end

    assign jtag_tdo_o = tdo_q;

endmodule

`default_nettype wire

/* verif/jtag_dtm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jtag_dtm_cfg.svh"

module jtag_dtm_tb;

    // tck lengths of the scan sequences, in tck periods
    localparam int RESET_TCK = 6;
    localparam int IR_TCK    = 11;
    localparam int DR32_TCK  = 37;
    localparam int DR44_TCK  = 49;
    localparam int TOTAL_TCK = (RESET_TCK + DR32_TCK) + (IR_TCK + DR32_TCK)
                             + (IR_TCK + 2 * DR32_TCK) + (IR_TCK + DR44_TCK)
                             + (IR_TCK + 2 * DR44_TCK)
                             + (IR_TCK + 7 + RESET_TCK + DR32_TCK);
    // 16 clk per tck, 4 ns per clk, twice the expected run
    localparam int TIMEOUT_NS = (TOTAL_TCK * 16 + 16) * 4 * 2;

    logic clk;
    logic rst_n;
    logic jtag_clk;
    logic jtag_tms;
    logic jtag_tdi;
    logic jtag_tdo;
    jtag_dtm_pkg::dmi_data_t rdata;
    logic ack;
    logic start_read;
    logic start_write;
    jtag_dtm_pkg::dmi_addr_t addr;
    jtag_dtm_pkg::dmi_data_t wdata;

    integer seed;
    int     errors;
    int     checks;
    int     read_pulses;
    int     write_pulses;
    // last request shifted into the dmi register
    jtag_dtm_pkg::dmi_req_t last_req;

    jtag_dtm_top jtag_dtm_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .jtag_clk_i    (jtag_clk),
        .jtag_tms_i    (jtag_tms),
        .jtag_tdi_i    (jtag_tdi),
        .jtag_tdo_o    (jtag_tdo),
        .rdata_i       (rdata),
        .ack_i         (ack),
        .start_read_o  (start_read),
        .start_write_o (start_write),
        .addr_o        (addr),
        .wdata_o       (wdata)
    );

    always #2 clk = ~clk;

    // strobe counters, sampled away from the active edge
    always @(negedge clk)
    begin
        if (start_read)
            read_pulses++;
        if (start_write)
            write_pulses++;
    end

    task automatic check_word(input string name, input jtag_dtm_pkg::word_t exp,
                              input jtag_dtm_pkg::word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_dmi(input string name, input jtag_dtm_pkg::dmi_req_t exp,
                             input jtag_dtm_pkg::dmi_req_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: expected addr 0x%03h data 0x%08h op %0d,",
                     name, exp.addr, exp.data, exp.op,
                     " actual addr 0x%03h data 0x%08h op %0d",
                     act.addr, act.data, act.op);
        end
    endtask

    task automatic check_addr(input string name, input jtag_dtm_pkg::dmi_addr_t exp,
                              input jtag_dtm_pkg::dmi_addr_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: expected 0x%03h, actual 0x%03h", name, exp, act);
        end
    endtask

    task automatic check_instr(input string name, input jtag_dtm_pkg::instr_t exp,
                               input jtag_dtm_pkg::instr_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // one tck period, falls first, tdo read just before the rise
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
        jtag_clk = 1'b0;
        repeat (4) @(negedge clk);
        jtag_tms = tms;
        jtag_tdi = tdi;
        repeat (4) @(negedge clk);
        tdo = jtag_tdo;
        jtag_clk = 1'b1;
        repeat (8) @(negedge clk);
    endtask

    // five tms ones, then into run-test/idle
    task automatic tap_reset();
        logic unused;
        repeat (5) tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
    endtask

    // from run-test/idle back to run-test/idle
    task automatic scan_ir(input jtag_dtm_pkg::instr_t ir_in,
                           output jtag_dtm_pkg::instr_t ir_out);
        logic bit_out;
        ir_out = '0;
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        for (int i = 0; i < `JTAG_IR_WIDTH; i++)
        begin
            tck_cycle(i == `JTAG_IR_WIDTH - 1, ir_in[i], bit_out);
            ir_out[i] = bit_out;
        end
        // exit1 to update, then idle
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    task automatic scan_dr(input int nbits, input logic [63:0] din,
                           output logic [63:0] dout);
        logic bit_out;
        dout = '0;
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        for (int i = 0; i < nbits; i++)
        begin
            tck_cycle(i == nbits - 1, din[i], bit_out);
            dout[i] = bit_out;
        end
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    task automatic reset_outputs();
        check_bit("tdo after reset", 1'b0, jtag_tdo);
        check_bit("start_read after reset", 1'b0, start_read);
        check_bit("start_write after reset", 1'b0, start_write);
    endtask

    // ir defaults to idcode
    task automatic idcode_after_reset();
        logic [63:0] dout;
        tap_reset();
        scan_dr(32, 64'h0, dout);
        check_word("idcode after reset", `JTAG_IDCODE_VAL, dout[31:0]);
    endtask

    task automatic bypass_delay();
        jtag_dtm_pkg::instr_t ir_out;
        jtag_dtm_pkg::word_t  pattern;
        logic [63:0]          dout;
        scan_ir(`JTAG_INSTR_BYPASS, ir_out);
        check_instr("ir capture", jtag_dtm_pkg::instr_t'(1), ir_out);
        pattern = $random(seed);
        scan_dr(32, {32'h0, pattern}, dout);
        // one bit late, the captured 0 leads
        check_word("bypass delay", {pattern[30:0], 1'b0}, dout[31:0]);
    endtask

    task automatic custom_readback();
        jtag_dtm_pkg::instr_t ir_out;
        jtag_dtm_pkg::word_t  wr_word;
        logic [63:0]          dout;
        scan_ir(`JTAG_INSTR_CUSTOM, ir_out);
        wr_word = $random(seed);
        scan_dr(32, {32'h0, wr_word}, dout);
        check_word("custom reset value", `JTAG_CUSTOM_RST, dout[31:0]);
        scan_dr(32, {32'h0, ~wr_word}, dout);
        check_word("custom readback", wr_word, dout[31:0]);
    endtask

    task automatic dmi_write();
        jtag_dtm_pkg::instr_t   ir_out;
        jtag_dtm_pkg::dmi_req_t req;
        logic [63:0]            dout;
        scan_ir(`JTAG_INSTR_DMI, ir_out);
        req.addr = jtag_dtm_pkg::dmi_addr_t'($random(seed));
        req.data = $random(seed);
        req.op   = jtag_dtm_pkg::DMI_OP_WRITE;
        read_pulses  = 0;
        write_pulses = 0;
        scan_dr(44, {20'h0, req}, dout);
        last_req = req;
        check_word("write strobe count", 1, write_pulses);
        check_word("read strobe count on write", 0, read_pulses);
        check_addr("write address", req.addr, addr);
        check_word("write data", req.data, wdata);
    endtask

    task automatic dmi_read();
        jtag_dtm_pkg::instr_t   ir_out;
        jtag_dtm_pkg::dmi_req_t req;
        jtag_dtm_pkg::dmi_req_t exp;
        jtag_dtm_pkg::dmi_data_t rd_word;
        logic [63:0]            dout;
        scan_ir(`JTAG_INSTR_DMI, ir_out);
        req.addr = jtag_dtm_pkg::dmi_addr_t'($random(seed));
        req.data = $random(seed);
        req.op   = jtag_dtm_pkg::DMI_OP_READ;
        read_pulses  = 0;
        write_pulses = 0;
        scan_dr(44, {20'h0, req}, dout);
        // capture returns the previous request untouched
        check_dmi("dmi previous request", last_req, jtag_dtm_pkg::dmi_req_t'(dout[43:0]));
        check_word("read strobe count", 1, read_pulses);
        check_word("write strobe count on read", 0, write_pulses);
        check_addr("read address", req.addr, addr);
        // bus answers with one ack
        rd_word = $random(seed);
        rdata = rd_word;
        ack   = 1'b1;
        @(negedge clk);
        ack   = 1'b0;
        repeat (2) @(negedge clk);
        read_pulses  = 0;
        write_pulses = 0;
        scan_dr(44, 64'h0, dout);
        exp.addr = req.addr;
        exp.data = rd_word;
        exp.op   = jtag_dtm_pkg::DMI_OP_NOP;
        check_dmi("dmi read response", exp, jtag_dtm_pkg::dmi_req_t'(dout[43:0]));
        check_word("strobes on nop", 0, read_pulses + write_pulses);
        last_req = '0;
    endtask

    // reset from the middle of a dr shift
    task automatic tms_reset();
        jtag_dtm_pkg::instr_t ir_out;
        logic                 unused;
        logic [63:0]          dout;
        scan_ir(`JTAG_INSTR_CUSTOM, ir_out);
        tck_cycle(1'b1, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
        tck_cycle(1'b0, 1'b0, unused);
        repeat (4) tck_cycle(1'b0, 1'b1, unused);
        tap_reset();
        scan_dr(32, 64'h0, dout);
        check_word("idcode after tms reset", `JTAG_IDCODE_VAL, dout[31:0]);
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        jtag_clk = 1'b0;
        jtag_tms = 1'b1;
        jtag_tdi = 1'b0;
        rdata    = '0;
        ack      = 1'b0;
        seed     = 39;
        errors   = 0;
        checks   = 0;
        read_pulses  = 0;
        write_pulses = 0;
        last_req = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_outputs();
        idcode_after_reset();
        bypass_delay();
        custom_readback();
        dmi_write();
        dmi_read();
        tms_reset();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hdl/jtag_dtm_pkg.sv
hdl/tck_sync.sv
hdl/tap_fsm.sv
hdl/scan_reg.sv
hdl/instr_reg.sv
hdl/dmi_bridge.sv
hdl/jtag_dtm_top.sv
verif/jtag_dtm_tb.sv

/* Bender.yml */
package:
  name: jtag_dtm

sources:
  - include_dirs:
      - include
    files:
      - hdl/jtag_dtm_pkg.sv
      - hdl/tck_sync.sv
      - hdl/tap_fsm.sv
      - hdl/scan_reg.sv
      - hdl/instr_reg.sv
      - hdl/dmi_bridge.sv
      - hdl/jtag_dtm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/jtag_dtm_tb.sv
